/* cdc_fifo_credit.f */
+incdir+logic
logic/cdc_fifo_data_pkg.sv
logic/cdc_fifo_ctrl_pkg.sv
logic/cdc_fifo_if.sv
logic/gray_sync.sv
logic/cdc_fifo_push_ctrl.sv
logic/cdc_fifo_pop_ctrl.sv
logic/cdc_fifo_ram.sv
logic/cdc_fifo_credit.sv
testbench/cdc_fifo_credit_sva.sv
testbench/cdc_fifo_credit_tb.sv

/* logic/cdc_fifo_credit.sv */
// Top level of the credit-in, ready/valid-out clock-domain-crossing FIFO
// Ties the push controller, the pop controller and the flop RAM together

`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_credit (
  input  logic                           push_clk,
  input  logic                           pop_clk,
  input  logic                           rst_n,

  // Push side, credit/valid
  output logic                           push_credit,
  input  logic                           push_valid,
  input  cdc_fifo_data_pkg::fifo_word_t  push_data,
  output logic                           push_full,
  output cdc_fifo_ctrl_pkg::fifo_count_t push_slots,

  // Pop side, ready/valid
  input  logic                           pop_ready,
  output logic                           pop_valid,
  output cdc_fifo_data_pkg::fifo_word_t  pop_data,
  output logic                           pop_empty,
  output cdc_fifo_ctrl_pkg::fifo_count_t pop_items
);
  import cdc_fifo_ctrl_pkg::*;
  import cdc_fifo_data_pkg::*;

  // ----------------------------------------
  // Internal connections
  // ----------------------------------------
  logic       wr_valid;
  fifo_addr_t wr_addr;
  fifo_word_t wr_data;

  cdc_ram_rd_if rd_if ();
  cdc_count_if  count_if ();

  // Push domain
  cdc_fifo_push_ctrl u_push_ctrl (
    .push_clk    (push_clk),
    .rst_n       (rst_n),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .push_credit (push_credit),
    .push_full   (push_full),
    .push_slots  (push_slots),
    .wr_valid    (wr_valid),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .counts      (count_if)
  );

  // Pop domain
  cdc_fifo_pop_ctrl u_pop_ctrl (
    .pop_clk   (pop_clk),
    .rst_n     (rst_n),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .pop_empty (pop_empty),
    .pop_items (pop_items),
    .rd        (rd_if),
    .counts    (count_if)
  );

  // Written on push_clk, read in the pop domain
  cdc_fifo_ram u_ram (
    .push_clk (push_clk),
    .wr_valid (wr_valid),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd       (rd_if)
  );

endmodule : cdc_fifo_credit

`default_nettype wire

/* logic/cdc_fifo_ctrl_pkg.sv */
// Control-state types and Gray helpers for the clock-domain-crossing FIFO
// Both controllers and the synchronizer import this package

`default_nettype none

`include "cdc_fifo_settings.svh"

package cdc_fifo_ctrl_pkg;

  // ----------------------------------------
  // Widths and types
  // ----------------------------------------

  localparam int ADDR_WIDTH = $clog2(`FIFO_DEPTH);

  // RAM index
  typedef logic [ADDR_WIDTH-1:0] fifo_addr_t;

  // Wrapping count with one extra bit so full and empty differ
  // The same type holds Gray values and slot or item totals
  typedef logic [ADDR_WIDTH:0] fifo_count_t;

  // Depth expressed in count width, used for the slot and credit math
  localparam fifo_count_t FIFO_DEPTH_COUNT = fifo_count_t'(`FIFO_DEPTH);

  // ----------------------------------------
  // Gray conversion
  // ----------------------------------------

  function automatic fifo_count_t bin2gray(input fifo_count_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the XOR of all Gray bits at and above it
  function automatic fifo_count_t gray2bin(input fifo_count_t gray);
    fifo_count_t bin;
    bin[ADDR_WIDTH] = gray[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage : cdc_fifo_ctrl_pkg

`default_nettype wire

/* logic/cdc_fifo_data_pkg.sv */
// Payload type for the clock-domain-crossing FIFO
// Shared by the RAM, both controllers and the top level

`default_nettype none

`include "cdc_fifo_settings.svh"

package cdc_fifo_data_pkg;

  // ----------------------------------------
  // Entry word
  // ----------------------------------------

  // One stored item, carried unchanged from push to pop
  typedef logic [`DATA_WIDTH-1:0] fifo_word_t;

endpackage : cdc_fifo_data_pkg

`default_nettype wire

/* logic/cdc_fifo_if.sv */
// Internal bundles of the clock-domain-crossing FIFO
// The read port links the pop controller to the RAM, the count bundle
// links the two controllers across the clock boundary

`timescale 1ns/1ps
`default_nettype none

// ----------------------------------------
// RAM read port, pop clock domain
// ----------------------------------------
interface cdc_ram_rd_if;
  import cdc_fifo_ctrl_pkg::*;
  import cdc_fifo_data_pkg::*;

  logic       rd_addr_valid;
  fifo_addr_t rd_addr;
  logic       rd_data_valid;
  fifo_word_t rd_data;

  modport ctrl (output rd_addr_valid, output rd_addr, input rd_data_valid, input rd_data);
  modport ram (input rd_addr_valid, input rd_addr, output rd_data_valid, output rd_data);
endinterface : cdc_ram_rd_if

// ----------------------------------------
// Gray counts and reset flags exchanged between the domains
// ----------------------------------------
// Every member leaves its source domain straight from a flop
interface cdc_count_if;
  import cdc_fifo_ctrl_pkg::*;

  fifo_count_t push_count_gray;
  logic        push_reset_active;
  fifo_count_t pop_count_gray;
  logic        pop_reset_active;

  modport push_side (
    output push_count_gray, output push_reset_active,
    input  pop_count_gray,  input  pop_reset_active
  );
  modport pop_side (
    input  push_count_gray, input  push_reset_active,
    output pop_count_gray,  output pop_reset_active
  );
endinterface : cdc_count_if

`default_nettype wire

/* logic/cdc_fifo_pop_ctrl.sv */
// Pop-side controller: reads the RAM and presents words as ready/valid
// Runs on pop_clk and learns about pushes through the synchronized count

`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_pop_ctrl (
  input  logic                           pop_clk,
  input  logic                           rst_n,
  input  logic                           pop_ready,
  output logic                           pop_valid,
  output cdc_fifo_data_pkg::fifo_word_t  pop_data,
  output logic                           pop_empty,
  output cdc_fifo_ctrl_pkg::fifo_count_t pop_items,
  cdc_ram_rd_if.ctrl                     rd,
  cdc_count_if.pop_side                  counts
);
  import cdc_fifo_ctrl_pkg::*;

  fifo_count_t rd_count;
  fifo_count_t rd_count_next;
  fifo_count_t rd_count_gray;
  logic        reset_active;
  fifo_count_t wr_count_sync;
  logic        push_in_reset;
  logic        pop_transfer;

  // ----------------------------------------
  // Reset flag toward the push side
  // ----------------------------------------
  always_ff @(posedge pop_clk) begin
    reset_active <= !rst_n;
  end

  // ----------------------------------------
  // Write count from the push domain
  // ----------------------------------------
  gray_sync u_wr_sync (
    .clk     (pop_clk),
    .rst_n   (rst_n),
    .gray_in (counts.push_count_gray),
    .flag_in (counts.push_reset_active),
    .count   (wr_count_sync),
    .flag    (push_in_reset)
  );

  // Items visible here lag the push side by the synchronizer depth
  assign pop_items = wr_count_sync - rd_count;
  assign pop_empty = (pop_items == '0);

  // ----------------------------------------
  // RAM read and pop handshake
  // ----------------------------------------
  // Read address always points at the oldest unread entry
  // With zero read latency the head word appears in the same cycle
  assign rd.rd_addr_valid = !pop_empty && !push_in_reset;
  assign rd.rd_addr       = rd_count[ADDR_WIDTH-1:0];

  // Head word stays put until it is taken, so pop_data is stable
  assign pop_valid = rd.rd_data_valid;
  assign pop_data  = rd.rd_data;

  assign pop_transfer  = pop_valid && pop_ready;
  assign rd_count_next = rd_count + fifo_count_t'(1);

  always_ff @(posedge pop_clk) begin
    if (!rst_n) begin
      rd_count      <= '0;
      rd_count_gray <= '0;
    end else if (pop_transfer) begin
      rd_count      <= rd_count_next;
      rd_count_gray <= bin2gray(rd_count_next);
    end
  end

  // Each pop here later turns into one credit on the push side
  assign counts.pop_count_gray   = rd_count_gray;
  assign counts.pop_reset_active = reset_active;

endmodule : cdc_fifo_pop_ctrl

`default_nettype wire

/* logic/cdc_fifo_push_ctrl.sv */
// Push-side controller: writes the RAM, tracks free slots and hands out credits
// Runs entirely on push_clk and sees the pop side only through synchronizers

`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_push_ctrl (
  input  logic                           push_clk,
  input  logic                           rst_n,
  input  logic                           push_valid,
  input  cdc_fifo_data_pkg::fifo_word_t  push_data,
  output logic                           push_credit,
  output logic                           push_full,
  output cdc_fifo_ctrl_pkg::fifo_count_t push_slots,
  output logic                           wr_valid,
  output cdc_fifo_ctrl_pkg::fifo_addr_t  wr_addr,
  output cdc_fifo_data_pkg::fifo_word_t  wr_data,
  cdc_count_if.push_side                 counts
);
  import cdc_fifo_ctrl_pkg::*;

  fifo_count_t wr_count;
  fifo_count_t wr_count_next;
  fifo_count_t wr_count_gray;
  logic        reset_active;
  fifo_count_t rd_count_sync;
  logic        pop_in_reset;
  fifo_count_t credit_count;
  fifo_count_t credit_owed;
  logic        push_accept;

  // ----------------------------------------
  // Reset flag toward the pop side
  // ----------------------------------------
  // Registered so the crossing sees a clean flop output
  always_ff @(posedge push_clk) begin
    reset_active <= !rst_n;
  end

  // ----------------------------------------
  // Read count from the pop domain
  // ----------------------------------------
  gray_sync u_rd_sync (
    .clk     (push_clk),
    .rst_n   (rst_n),
    .gray_in (counts.pop_count_gray),
    .flag_in (counts.pop_reset_active),
    .count   (rd_count_sync),
    .flag    (pop_in_reset)
  );

  // Occupancy as seen from here is pessimistic, since pops show up late
  assign push_slots = FIFO_DEPTH_COUNT - (wr_count - rd_count_sync);
  assign push_full  = (push_slots == '0);

  // A push without room is a sender error; the word is dropped
  assign push_accept = push_valid && !push_full;

  // RAM write happens on the same edge that bumps the write count
  assign wr_valid = push_accept;
  assign wr_addr  = wr_count[ADDR_WIDTH-1:0];
  assign wr_data  = push_data;

  // ----------------------------------------
  // Credit return
  // ----------------------------------------
  // Owed credits are the depth plus every pop seen so far, minus the
  // credits already issued, all in wrapping count arithmetic
  assign credit_owed = rd_count_sync + FIFO_DEPTH_COUNT - credit_count;

  // Held back while the pop side still looks like it is in reset
  assign push_credit = (credit_owed != '0) && !pop_in_reset;

  assign wr_count_next = wr_count + fifo_count_t'(1);

  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      wr_count      <= '0;
      wr_count_gray <= '0;
      credit_count  <= '0;
    end else begin
      if (push_accept) begin
        wr_count      <= wr_count_next;
        wr_count_gray <= bin2gray(wr_count_next);
      end
      if (push_credit) begin
        credit_count <= credit_count + fifo_count_t'(1);
      end
    end
  end

  // Both leave straight from flops above
  assign counts.push_count_gray   = wr_count_gray;
  assign counts.push_reset_active = reset_active;

endmodule : cdc_fifo_push_ctrl

`default_nettype wire

/* logic/cdc_fifo_ram.sv */
// Flop-array storage for the FIFO with one write port and one read port
// Writes land on the next push edge and reads are purely combinational

`timescale 1ns/1ps
`default_nettype none

`include "cdc_fifo_settings.svh"

module cdc_fifo_ram (
  input  logic                          push_clk,
  input  logic                          wr_valid,
  input  cdc_fifo_ctrl_pkg::fifo_addr_t wr_addr,
  input  cdc_fifo_data_pkg::fifo_word_t wr_data,
  cdc_ram_rd_if.ram                     rd
);
  import cdc_fifo_data_pkg::*;

  // Payload words hold no defined value until they are first written
  fifo_word_t mem [`FIFO_DEPTH];

  always_ff @(posedge push_clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // The pop side only addresses entries whose write count it has seen,
  // and that count crossed a synchronizer, so the entry is long settled
  assign rd.rd_data       = mem[rd.rd_addr];
  assign rd.rd_data_valid = rd.rd_addr_valid;

endmodule : cdc_fifo_ram

`default_nettype wire

/* logic/cdc_fifo_settings.svh */
// Build-time constants for the credit-based clock-domain-crossing FIFO
// Included by the packages and by any block that needs a raw constant

`ifndef CDC_FIFO_SETTINGS_SVH
`define CDC_FIFO_SETTINGS_SVH

// ----------------------------------------
// Sizing
// ----------------------------------------

// Number of entries, must be a power of two
`define FIFO_DEPTH 8

// Bits per stored word
`define DATA_WIDTH 16

// Flops per synchronizer chain on each crossing
`define SYNC_STAGES 3

`endif

/* logic/gray_sync.sv */
// Brings a Gray-coded count and a reset-active flag into the local clock
// Output count is already converted back to binary

`timescale 1ns/1ps
`default_nettype none

`include "cdc_fifo_settings.svh"

module gray_sync (
  input  logic                           clk,
  input  logic                           rst_n,
  input  cdc_fifo_ctrl_pkg::fifo_count_t gray_in,
  input  logic                           flag_in,
  output cdc_fifo_ctrl_pkg::fifo_count_t count,
  output logic                           flag
);
  import cdc_fifo_ctrl_pkg::*;

  // Stage 0 samples the far domain, the last stage is safe to use
  fifo_count_t [`SYNC_STAGES-1:0] gray_q;
  logic        [`SYNC_STAGES-1:0] flag_q;

  // ----------------------------------------
  // Synchronizer chains
  // ----------------------------------------
  // Reset fills the flag chain with ones, so the far side looks busy in
  // reset until a real low flag has walked through every stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gray_q <= '0;
      flag_q <= '1;
    end else begin
      gray_q <= {gray_q[`SYNC_STAGES-2:0], gray_in};
      flag_q <= {flag_q[`SYNC_STAGES-2:0], flag_in};
    end
  end

  // Only one Gray bit moves per far-side step, so the sampled value is
  // always either the old or the new count
  assign count = gray2bin(gray_q[`SYNC_STAGES-1]);
  assign flag  = flag_q[`SYNC_STAGES-1];

endmodule : gray_sync

`default_nettype wire

/* testbench/cdc_fifo_credit_sva.sv */
// Protocol assertions on the FIFO's top-level ports, attached with bind
// Each failure also bumps fail_count, which the testbench polls

`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_credit_sva (
  input logic                          push_clk,
  input logic                          pop_clk,
  input logic                          rst_n,
  input logic                          push_credit,
  input logic                          push_valid,
  input logic                          push_full,
  input logic                          pop_ready,
  input logic                          pop_valid,
  input cdc_fifo_data_pkg::fifo_word_t pop_data
);
  int   fail_count = 0;
  logic push_rst_seen;
  logic pop_rst_seen;

  // High once reset was already sampled on the previous edge, so the
  // registers have been cleared by then
  always_ff @(posedge push_clk) begin
    push_rst_seen <= !rst_n;
  end

  always_ff @(posedge pop_clk) begin
    pop_rst_seen <= !rst_n;
  end

  // ----------------------------------------
  // Push side
  // ----------------------------------------
  // A sender holding a credit always finds room
  push_while_full_chk: assert property (@(posedge push_clk) disable iff (!rst_n)
    push_full |-> !push_valid)
    else begin
      $error("push_valid asserted while push_full is high");
      fail_count++;
    end

  push_reset_chk: assert property (@(posedge push_clk)
    (!rst_n && push_rst_seen) |-> (!push_credit && !push_full))
    else begin
      $error("push_credit or push_full high during reset");
      fail_count++;
    end

  // The pop side still looks busy here, so no credit may leave yet
  push_release_chk: assert property (@(posedge push_clk)
    $rose(rst_n) |=> (!push_credit && !push_full))
    else begin
      $error("push_credit or push_full high right after reset");
      fail_count++;
    end

  // ----------------------------------------
  // Pop side
  // ----------------------------------------
  pop_hold_chk: assert property (@(posedge pop_clk) disable iff (!rst_n)
    (pop_valid && !pop_ready) |=> $stable(pop_data))
    else begin
      $error("pop_data changed while waiting for pop_ready");
      fail_count++;
    end

  pop_reset_chk: assert property (@(posedge pop_clk)
    (!rst_n && pop_rst_seen) |-> !pop_valid)
    else begin
      $error("pop_valid high during reset");
      fail_count++;
    end

  pop_release_chk: assert property (@(posedge pop_clk)
    $rose(rst_n) |=> !pop_valid)
    else begin
      $error("pop_valid high right after reset");
      fail_count++;
    end

endmodule : cdc_fifo_credit_sva

bind cdc_fifo_credit cdc_fifo_credit_sva u_sva (
  .push_clk    (push_clk),
  .pop_clk     (pop_clk),
  .rst_n       (rst_n),
  .push_credit (push_credit),
  .push_valid  (push_valid),
  .push_full   (push_full),
  .pop_ready   (pop_ready),
  .pop_valid   (pop_valid),
  .pop_data    (pop_data)
);

`default_nettype wire

/* testbench/cdc_fifo_credit_tb.sv */
// Testbench for the credit-based clock-domain-crossing FIFO
// Pushes the data file's words under credit control, pops them with the
// file's ready hold-offs and checks order, credits and status counts

`timescale 1ns/1ps
`default_nettype none

`include "cdc_fifo_settings.svh"

module cdc_fifo_credit_tb;
  import cdc_fifo_ctrl_pkg::*;
  import cdc_fifo_data_pkg::*;

  localparam int NUM_ITEMS    = 32;
  localparam int RESET_CYCLES = 8;
  localparam int PAUSE_AT     = 24;
  localparam int SETTLE       = `SYNC_STAGES + 2;

  logic        push_clk;
  logic        pop_clk;
  logic        rst_n;
  logic        push_credit;
  logic        push_valid;
  fifo_word_t  push_data;
  logic        push_full;
  fifo_count_t push_slots;
  logic        pop_ready;
  logic        pop_valid;
  fifo_word_t  pop_data;
  logic        pop_empty;
  fifo_count_t pop_items;

  // Each item takes two words with the push word first and its hold-off second
  logic [15:0] testdata [0:2*NUM_ITEMS-1];

  int   credits_held = 0;
  int   credit_total = 0;
  int   pushes       = 0;
  int   pops         = 0;
  int   hold_left    = 0;
  int   cycle_count  = 0;
  int   cycle_limit  = 0;
  logic pause_req    = 1'b0;
  logic saw_full     = 1'b0;

  cdc_fifo_credit i_cdc_fifo_credit (
    .push_clk    (push_clk),
    .pop_clk     (pop_clk),
    .rst_n       (rst_n),
    .push_credit (push_credit),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .push_full   (push_full),
    .push_slots  (push_slots),
    .pop_ready   (pop_ready),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .pop_empty   (pop_empty),
    .pop_items   (pop_items)
  );

  // ----------------------------------------
  // Clocks
  // ----------------------------------------
  initial push_clk = 1'b0;
  always #50 push_clk = ~push_clk;

  // The pop clock runs at the same rate but its edges fall between push edges
  initial pop_clk = 1'b0;
  always begin
    #37;
    forever #50 pop_clk = ~pop_clk;
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic stop_on_failure;
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  // The sender drives one word on every push cycle in which it holds a credit
  task automatic send_items(input int upto);
    while (pushes < upto) begin
      @(posedge push_clk);
      #5;
      if (credits_held > 0) begin
        push_valid = 1'b1;
        push_data  = testdata[2*pushes];
        pushes     = pushes + 1;
      end else begin
        push_valid = 1'b0;
      end
    end
    @(posedge push_clk);
    #5;
    push_valid = 1'b0;
  endtask

  // With both sides idle the counts must agree once the crossings settle
  task automatic pause_and_check(input string name);
    int outstanding;
    pause_req = 1'b1;
    repeat (SETTLE) @(posedge push_clk);
    #5;
    outstanding = pushes - pops;
    check_value({name, " pop_items"}, outstanding, pop_items);
    check_value({name, " push_slots"}, `FIFO_DEPTH - outstanding, push_slots);
    check_value({name, " pop_empty"}, outstanding == 0, pop_empty);
    check_value({name, " push_full"}, outstanding == `FIFO_DEPTH, push_full);
    pause_req = 1'b0;
  endtask

  // ----------------------------------------
  // Push-side monitor and timeout
  // ----------------------------------------
  // Credit bookkeeping happens at the edge and the sender reads it 5 ns later
  always @(posedge push_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run still busy after %0d push cycles", cycle_limit);
      stop_on_failure();
    end
    if (i_cdc_fifo_credit.u_sva.fail_count != 0) begin
      $display("a protocol assertion on the FIFO ports failed");
      stop_on_failure();
    end
    if (rst_n) begin
      if (push_credit) begin
        credits_held = credits_held + 1;
        credit_total = credit_total + 1;
      end
      if (push_valid) begin
        credits_held = credits_held - 1;
      end
      // A full FIFO means every credit is spent and none may come back yet
      if (push_full) begin
        saw_full = 1'b1;
        check_value("credit while full", 0, push_credit);
        check_value("credits held while full", 0, credits_held);
      end
    end
  end

  // ----------------------------------------
  // Receiver
  // ----------------------------------------
  // Hold-off counts pop cycles with ready low before each item is taken
  always @(posedge pop_clk) begin
    if (rst_n) begin
      if (pop_valid && pop_ready) begin
        check_value("pop data order", testdata[2*pops], pop_data);
        pops = pops + 1;
        if (pops < NUM_ITEMS) begin
          hold_left = testdata[2*pops+1];
        end
      end else if (!pause_req && hold_left > 0) begin
        hold_left = hold_left - 1;
      end
    end
    #5;
    pop_ready = rst_n && !pause_req && (hold_left == 0) && (pops < NUM_ITEMS);
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int max_hold;
    rst_n      = 1'b0;
    push_valid = 1'b0;
    push_data  = '0;
    pop_ready  = 1'b0;
    $readmemh("testbench/cdc_fifo_credit_testdata.hex", testdata);

    // Budget per item covers a full FIFO, the longest hold-off and both crossings
    max_hold = 0;
    for (int i = 0; i < NUM_ITEMS; i++) begin
      if (testdata[2*i+1] > max_hold) begin
        max_hold = testdata[2*i+1];
      end
    end
    cycle_limit = NUM_ITEMS * (`FIFO_DEPTH + max_hold + 2 * `SYNC_STAGES + 4) + RESET_CYCLES;
    hold_left   = testdata[1];

    repeat (RESET_CYCLES) @(posedge push_clk);
    #5;
    rst_n = 1'b1;

    // Initial credits arrive without any push and then stop at the depth
    do begin
      @(posedge push_clk);
      #5;
    end while (credits_held < `FIFO_DEPTH);
    repeat (SETTLE) @(posedge push_clk);
    #5;
    check_value("initial credits", `FIFO_DEPTH, credit_total);
    check_value("initial slots", `FIFO_DEPTH, push_slots);
    check_value("initial empty", 1, pop_empty);
    check_value("initial items", 0, pop_items);

    send_items(PAUSE_AT);
    pause_and_check("mid-test");
    send_items(NUM_ITEMS);

    do begin
      @(posedge push_clk);
      #5;
    end while (pops < NUM_ITEMS);
    pause_and_check("final");

    // Every pop returns exactly one credit on top of the initial ones
    check_value("total credits", `FIFO_DEPTH + NUM_ITEMS, credit_total);
    check_value("credits held at end", `FIFO_DEPTH, credits_held);
    check_value("back-pressure reached full", 1, saw_full);

    if (i_cdc_fifo_credit.u_sva.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("protocol assertions failed during the run");
      stop_on_failure();
    end
  end

endmodule : cdc_fifo_credit_tb

`default_nettype wire

/* testbench/cdc_fifo_credit_testdata.hex */
// Column 1: 16-bit push word, in push order
// Column 2: pop cycles with pop_ready low before that item is taken
1001 00
2b4e 00
3c7a 01
4d19 00
5ef2 02
6a83 00
7b64 00
8c05 03
9dd6 00
aea7 01
bf38 00
c049 00
d15a 14
e26b 00
f37c 00
048d 01
159e 00
26af 00
37b0 02
48c1 00
59d2 00
6ae3 01
7bf4 00
8c0f 00
9d10 03
ae21 00
bf32 00
c043 01
d154 00
ffff 00
f376 02
0000 00
